// ==== rtl/cart_cfg.svh ====
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// --------------------
// bus widths
// --------------------
`define CART_ADDR_W    16        // cpu cartridge address
`define DL_ADDR_W      25        // download byte address
`define ROM_ADDR_W     23        // mapped rom byte address, 8 MB
`define CRAM_ADDR_W    17        // cartridge ram byte address, 128 KB
`define SECTOR_ADDR_W  8         // word index inside one 512 byte sector
`define LBA_W          32        // block port sector number

// --------------------
// cartridge header
// --------------------
// upper byte of this word holds the mapper type
`define HDR_MBC_OFS    'h146
// low byte rom size code, high byte ram size code
`define HDR_SIZE_OFS   'h148

// low nibble written to 0000-1FFF that opens the ram
`define RAM_KEY        4'hA

`endif

// ==== rtl/cart_pkg.sv ====
package cart_pkg;

	// --------------------
	// mapper kinds
	// --------------------
	// only the two banking schemes kept in this core
	typedef enum logic [1:0] {
		MBC_NONE = 2'd0,    // 32 KB flat rom, no banking
		MBC_1    = 2'd1,    // header types 1..3
		MBC_5    = 2'd2     // header types 25..30
	} mbc_kind_t;

	// --------------------
	// bank numbers
	// --------------------
	// mbc5 reaches 512 banks of 16 KB
	typedef logic [8:0] rom_bank_t;

	// up to 16 banks of 8 KB
	typedef logic [3:0] ram_bank_t;

	// --------------------
	// data
	// --------------------
	typedef logic [7:0] cart_byte_t;    // cpu side byte

	// download words and block buffer words share one shape
	// low byte is the even address
	typedef logic [15:0] dl_word_t;

endpackage

// ==== rtl/cart_header.sv ====
`include "cart_cfg.svh"

module cart_header (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,      // whole cartridge download
	input  logic                    dl_wr,          // one cycle word strobe
	input  logic [`DL_ADDR_W-1:0]   dl_addr,        // even byte address
	input  cart_pkg::dl_word_t      dl_data,
	output cart_pkg::mbc_kind_t     mbc_kind,
	output cart_pkg::rom_bank_t     rom_mask,
	output cart_pkg::ram_bank_t     ram_mask,
	output cart_pkg::cart_byte_t    ram_size_code,
	output logic                    save_capable
);
	import cart_pkg::*;

	cart_byte_t mbc_type;    // header byte 0x147
	cart_byte_t rom_size;    // header byte 0x148

	logic hdr_wr;
	assign hdr_wr = dl_active & dl_wr;

	// --------------------
	// latch header bytes as the rom streams past
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mbc_type      <= '0;
			rom_size      <= '0;
			ram_size_code <= '0;
		end else if (hdr_wr) begin
			if (dl_addr == `DL_ADDR_W'(`HDR_MBC_OFS))
				mbc_type <= dl_data[15:8];    // odd byte of the word
			if (dl_addr == `DL_ADDR_W'(`HDR_SIZE_OFS)) begin
				rom_size      <= dl_data[7:0];
				ram_size_code <= dl_data[15:8];
			end
		end
	end

	// decode from the latched bytes
	always_comb begin
		if (mbc_type >= 8'd1 && mbc_type <= 8'd3)
			mbc_kind = MBC_1;
		else if (mbc_type >= 8'd25 && mbc_type <= 8'd30)
			mbc_kind = MBC_5;
		else
			mbc_kind = MBC_NONE;    // also reset value, header reads zero

		// code n means 2^(n+1) banks
		if (rom_size <= 8'd8)
			rom_mask = rom_bank_t'((10'd2 << rom_size[3:0]) - 10'd1);
		else
			rom_mask = 9'd127;      // odd sizes like 0x52..0x54 mirror in 128

		case (ram_size_code)
			8'd0, 8'd1, 8'd2: ram_mask = 4'd0;    // 8 KB or less, one bank
			8'd3:             ram_mask = 4'd3;    // 32 KB
			default:          ram_mask = 4'd15;   // 128 KB
		endcase
	end

	// battery types among the kept mappers
	assign save_capable = (mbc_type == 8'h03 || mbc_type == 8'h1B || mbc_type == 8'h1E)
		&& (ram_size_code != 8'd0);

endmodule

// ==== rtl/mbc_regs.sv ====
`include "cart_cfg.svh"

module mbc_regs (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic [`CART_ADDR_W-1:0]  cart_addr,
	input  logic                     cart_rd,
	input  logic                     cart_wr,
	input  cart_pkg::cart_byte_t     cart_di,
	input  cart_pkg::mbc_kind_t      mbc_kind,
	input  cart_pkg::rom_bank_t      rom_mask,
	input  cart_pkg::ram_bank_t      ram_mask,
	input  cart_pkg::cart_byte_t     cram_q,      // one cycle after cram_addr
	output logic [`ROM_ADDR_W-1:0]   rom_addr,
	output cart_pkg::cart_byte_t     cart_do,
	output logic [`CRAM_ADDR_W-1:0]  cram_addr,
	output logic                     cram_wr
);
	import cart_pkg::*;

	rom_bank_t  rom_bank;      // as written by the cpu
	ram_bank_t  ram_bank;
	logic       mbc1_mode;     // 0 = 16/8 mode, 1 = 4/32 mode
	logic       ram_enable;
	logic       rd_ena;        // ram read seen while enabled
	logic       is_cram;       // A000-BFFF
	logic [6:0] mbc1_bank;
	rom_bank_t  mapped_bank;
	rom_bank_t  bank_sel;
	ram_bank_t  cram_bank;

	assign is_cram = (cart_addr[15:13] == 3'b101);

	// --------------------
	// register writes
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank   <= 9'd1;
			ram_bank   <= '0;
			mbc1_mode  <= 1'b0;
			ram_enable <= 1'b0;
		end else if (cart_wr) begin
			case (cart_addr[15:13])
				3'b000: ram_enable <= (cart_di[3:0] == `RAM_KEY);
				3'b001: begin
					if (mbc_kind == MBC_5) begin
						if (cart_addr[12])
							rom_bank[8] <= cart_di[0];      // 3000-3FFF
						else
							rom_bank[7:0] <= cart_di;       // 2000-2FFF
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank <= 9'd1;                 // bank 0 reads as 1
					end else begin
						rom_bank <= {2'b00, cart_di[6:0]};
					end
				end
				3'b010: begin
					if (mbc_kind == MBC_5)
						ram_bank <= cart_di[3:0];
					else
						ram_bank <= {2'b00, cart_di[1:0]};
				end
				3'b011: begin
					if (mbc_kind == MBC_1)
						mbc1_mode <= cart_di[0];
				end
				default: ;    // ram and upper space hold no registers
			endcase
		end
	end

	// --------------------
	// rom mapping
	// --------------------
	always_comb begin
		// mode 0 drives the ram bank bits onto rom bank bits 6..5
		mbc1_bank = {mbc1_mode ? 2'b00 : ram_bank[1:0], rom_bank[4:0]} & rom_mask[6:0];
		case (mbc_kind)
			MBC_1:   mapped_bank = {2'b00, mbc1_bank};
			MBC_5:   mapped_bank = rom_bank & rom_mask;    // bank 0 allowed here
			default: mapped_bank = 9'd1;                   // flat 32 KB
		endcase
		bank_sel = (cart_addr[15:14] == 2'b01) ? mapped_bank : 9'd0;
	end

	assign rom_addr = {bank_sel, cart_addr[13:0]};    // bank * 16 KB + offset

	// --------------------
	// ram mapping
	// --------------------
	always_comb begin
		if (mbc_kind == MBC_1)    // banked only in mode 1
			cram_bank = {2'b00, (mbc1_mode ? ram_bank[1:0] : 2'b00) & ram_mask[1:0]};
		else
			cram_bank = ram_bank & ram_mask;
	end

	assign cram_addr = {cram_bank, cart_addr[12:0]};
	assign cram_wr   = cart_wr & is_cram & ram_enable;    // closed ram ignores writes

	// enable sampled with the strobe, data follows one cycle later
	always_ff @(posedge clk_sys) begin
		if (reset)
			rd_ena <= 1'b0;
		else
			rd_ena <= cart_rd & is_cram & ram_enable;
	end

	assign cart_do = rd_ena ? cram_q : 8'hFF;

endmodule

// ==== rtl/cart_ram.sv ====
`include "cart_cfg.svh"

module cart_ram (
	input  logic                                          clk_sys,
	input  logic [`CRAM_ADDR_W-1:0]                       cram_addr,
	input  logic                                          cram_wr,
	input  cart_pkg::cart_byte_t                          cart_di,
	input  logic [`SECTOR_ADDR_W-1:0]                     sd_buff_addr,
	input  logic [`CRAM_ADDR_W-`SECTOR_ADDR_W-2:0]        sd_lba,     // low lba bits
	input  logic                                          sd_buff_wr,
	input  logic                                          sd_ack,
	input  cart_pkg::dl_word_t                            sd_buff_dout,
	output cart_pkg::cart_byte_t                          cram_q,
	output cart_pkg::dl_word_t                            sd_buff_din
);
	import cart_pkg::*;

	localparam int LANE_AW = `CRAM_ADDR_W - 1;    // word address into each lane

	logic [LANE_AW-1:0] a_addr;      // cpu port
	logic [LANE_AW-1:0] b_addr;      // block port
	logic               b_wr;
	logic               lane_sel;    // odd byte of the last cpu access

	assign a_addr = cram_addr[`CRAM_ADDR_W-1:1];
	assign b_addr = {sd_lba, sd_buff_addr};    // sector then word
	assign b_wr   = sd_buff_wr & sd_ack;       // host writes only inside a transfer

	// --------------------
	// byte lanes
	// --------------------
	// lane 0 holds even bytes, lane 1 odd bytes
	for (genvar l = 0; l < 2; l++) begin : g_lane
		cart_byte_t mem [2**LANE_AW];
		cart_byte_t q_a;
		cart_byte_t q_b;

		always_ff @(posedge clk_sys) begin
			if (cram_wr && cram_addr[0] == 1'(l))
				mem[a_addr] <= cart_di;
			if (b_wr)
				mem[b_addr] <= sd_buff_dout[8*l +: 8];    // block port wins a clash
			q_a <= mem[a_addr];
			q_b <= mem[b_addr];
		end
	end

	always_ff @(posedge clk_sys)
		lane_sel <= cram_addr[0];    // line up with the registered lane data

	assign cram_q      = lane_sel ? g_lane[1].q_a : g_lane[0].q_a;
	assign sd_buff_din = {g_lane[1].q_b, g_lane[0].q_b};

endmodule

// ==== rtl/backup_sequencer.sv ====
`include "cart_cfg.svh"

module backup_sequencer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  logic                  img_mounted,    // save image mount pulse
	input  logic                  img_readonly,
	input  logic                  bk_load,
	input  logic                  bk_save,
	input  logic                  save_capable,
	input  cart_pkg::cart_byte_t  ram_size_code,
	input  logic                  sd_ack,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic [`LBA_W-1:0]     sd_lba,
	output logic                  bk_busy
);
	import cart_pkg::*;

	typedef enum logic [1:0] {
		BK_IDLE,    // waiting for a trigger
		BK_REQ,     // request up, waiting for ack to rise
		BK_XFER     // host moving the sector
	} bk_state_t;

	bk_state_t  state;
	logic       loading;     // direction of the running job
	logic       bk_ena;      // writable image mounted with this rom
	logic       old_dl;
	logic       old_load;
	logic       old_save;
	logic       old_ack;
	logic       load_rise;
	logic       save_rise;
	cart_byte_t last_lba;

	assign load_rise = bk_load & ~old_load;
	assign save_rise = bk_save & ~old_save;

	// sectors of 512 bytes per ram size
	always_comb begin
		case (ram_size_code)
			8'd0, 8'd1: last_lba = 8'd3;     // 2 KB still saves 2 KB
			8'd2:       last_lba = 8'd15;    // 8 KB
			8'd3:       last_lba = 8'd63;    // 32 KB
			default:    last_lba = 8'd255;   // 128 KB
		endcase
	end

	// --------------------
	// enable and edges
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena   <= 1'b0;
			old_dl   <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_dl   <= dl_active;
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_ack;
			if (dl_active & ~old_dl)
				bk_ena <= 1'b0;    // new rom forgets the old image
			if (dl_active && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
		end
	end

	// --------------------
	// sector loop
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= BK_IDLE;
			loading <= 1'b0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
			sd_lba  <= '0;
		end else begin
			case (state)
				BK_IDLE: begin
					if (bk_ena && save_capable && (load_rise || save_rise)) begin
						state   <= BK_REQ;
						loading <= load_rise;    // load wins if both rise
						sd_lba  <= '0;
						sd_rd   <= load_rise;
						sd_wr   <= ~load_rise;
					end
				end
				BK_REQ: begin
					if (sd_ack & ~old_ack) begin    // host took the request
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_XFER;
					end
				end
				BK_XFER: begin
					if (~sd_ack & old_ack) begin
						if (sd_lba[7:0] == last_lba) begin
							state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= loading;
							sd_wr  <= ~loading;
							state  <= BK_REQ;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	assign bk_busy = (state != BK_IDLE);

endmodule

// ==== rtl/cart_top.sv ====
`include "cart_cfg.svh"

module cart_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	// download
	input  logic                     dl_active,
	input  logic                     dl_wr,
	input  logic [`DL_ADDR_W-1:0]    dl_addr,
	input  cart_pkg::dl_word_t       dl_data,
	// cpu side
	input  logic [`CART_ADDR_W-1:0]  cart_addr,
	input  logic                     cart_rd,
	input  logic                     cart_wr,
	input  cart_pkg::cart_byte_t     cart_di,
	output logic [`ROM_ADDR_W-1:0]   rom_addr,
	output cart_pkg::cart_byte_t     cart_do,
	// save image control
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic                     bk_load,
	input  logic                     bk_save,
	output logic                     bk_busy,
	// block port
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic [`LBA_W-1:0]        sd_lba,
	input  logic                     sd_ack,
	input  logic [`SECTOR_ADDR_W-1:0] sd_buff_addr,
	input  logic                     sd_buff_wr,
	input  cart_pkg::dl_word_t       sd_buff_dout,
	output cart_pkg::dl_word_t       sd_buff_din
);
	import cart_pkg::*;

	mbc_kind_t              mbc_kind;
	rom_bank_t              rom_mask;
	ram_bank_t              ram_mask;
	cart_byte_t             ram_size_code;
	logic                   save_capable;
	logic [`CRAM_ADDR_W-1:0] cram_addr;
	logic                   cram_wr;
	cart_byte_t             cram_q;

	// --------------------
	// header feeds all three
	// --------------------
	cart_header u_header (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_addr, .dl_data,
		.mbc_kind, .rom_mask, .ram_mask, .ram_size_code, .save_capable
	);

	mbc_regs u_mbc (
		.clk_sys, .reset, .cart_addr, .cart_rd, .cart_wr, .cart_di,
		.mbc_kind, .rom_mask, .ram_mask, .cram_q,
		.rom_addr, .cart_do, .cram_addr, .cram_wr
	);

	// ram sees only the sector bits that fit 128 KB
	cart_ram u_ram (
		.clk_sys, .cram_addr, .cram_wr, .cart_di,
		.sd_buff_addr,
		.sd_lba      (sd_lba[`CRAM_ADDR_W-`SECTOR_ADDR_W-2:0]),
		.sd_buff_wr, .sd_ack, .sd_buff_dout,
		.cram_q, .sd_buff_din
	);

	backup_sequencer u_backup (
		.clk_sys, .reset, .dl_active, .img_mounted, .img_readonly,
		.bk_load, .bk_save, .save_capable, .ram_size_code, .sd_ack,
		.sd_rd, .sd_wr, .sd_lba, .bk_busy
	);

endmodule

// ==== testbench/tb_cart.sv ====
`include "cart_cfg.svh"

module tb_cart;
	timeunit 1ns;
	timeprecision 100ps;
	import cart_pkg::*;

	// --------------------
	// run length
	// --------------------
	localparam int SECTOR_CYC  = 270;                  // ack wait plus 257 word slots plus hand-off
	localparam int BACKUP_CYC  = 2 * 64 * SECTOR_CYC;  // one load and one save of 32 KB
	localparam int CPU_CYC     = 4000;                 // rom, ram and refusal tests with margin
	localparam int TIMEOUT_CYC = BACKUP_CYC + CPU_CYC;

	logic                      clk_sys = 1'b0;
	logic                      reset;
	logic                      dl_active;
	logic                      dl_wr;
	logic [`DL_ADDR_W-1:0]     dl_addr;
	dl_word_t                  dl_data;
	logic [`CART_ADDR_W-1:0]   cart_addr;
	logic                      cart_rd;
	logic                      cart_wr;
	cart_byte_t                cart_di;
	logic [`ROM_ADDR_W-1:0]    rom_addr;
	cart_byte_t                cart_do;
	logic                      img_mounted;
	logic                      img_readonly;
	logic                      bk_load;
	logic                      bk_save;
	logic                      bk_busy;
	logic                      sd_rd;
	logic                      sd_wr;
	logic [`LBA_W-1:0]         sd_lba;
	logic                      sd_ack;
	logic [`SECTOR_ADDR_W-1:0] sd_buff_addr;
	logic                      sd_buff_wr;
	dl_word_t                  sd_buff_dout;
	dl_word_t                  sd_buff_din;

	// predicted mapper state
	mbc_kind_t  m_kind;
	rom_bank_t  m_rom_bank;
	rom_bank_t  m_rom_mask;
	ram_bank_t  m_ram_bank;
	ram_bank_t  m_ram_mask;
	cart_byte_t m_ram_code;
	logic       m_mode;
	logic       m_ram_en;
	cart_byte_t model_ram [2**`CRAM_ADDR_W];    // cartridge ram contents

	cart_byte_t exp_q[$];    // expected cart_do values in read order
	cart_byte_t rd_exp;
	logic       rd_seen;
	string      test_name;
	int         checks = 0;
	int         errors = 0;

	cart_top uut (.*);

	always #2 clk_sys = ~clk_sys;

	// --------------------
	// reference functions
	// --------------------
	function automatic logic [`ROM_ADDR_W-1:0] rom_ref(input logic [15:0] a);
		rom_bank_t bank;
		if (a[15:14] == 2'b00)
			bank = 9'd0;    // fixed bank 0
		else if (m_kind == MBC_1)
			bank = {2'b00, (m_mode ? 2'b00 : m_ram_bank[1:0]), m_rom_bank[4:0]} & m_rom_mask;
		else if (m_kind == MBC_5)
			bank = m_rom_bank & m_rom_mask;
		else
			bank = 9'd1;    // plain 32 KB rom is linear
		return {bank, a[13:0]};
	endfunction

	function automatic logic [`CRAM_ADDR_W-1:0] cram_ref(input logic [15:0] a);
		ram_bank_t bank;
		bank = m_ram_bank & m_ram_mask;
		if (m_kind == MBC_1 && !m_mode)
			bank = 4'd0;    // mode 0 keeps ram in bank 0
		return {bank, a[12:0]};
	endfunction

	function automatic int last_lba_ref(input cart_byte_t code);
		if (code <= 8'd1)
			return 3;
		if (code == 8'd2)
			return 15;
		return (code == 8'd3) ? 63 : 255;
	endfunction

	// --------------------
	// stimulus tasks
	// --------------------
	task automatic send_word(input logic [`DL_ADDR_W-1:0] addr, input dl_word_t data);
		@(posedge clk_sys);
		#0.5;
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(posedge clk_sys);
		#0.5 dl_wr = 1'b0;
	endtask

	task automatic download(input cart_byte_t mbc_type, input cart_byte_t rom_code,
			input cart_byte_t ram_code, input logic mount, input logic readonly);
		@(posedge clk_sys);
		#0.5 dl_active = 1'b1;
		send_word(`HDR_MBC_OFS, {mbc_type, 8'($urandom)});
		send_word(`HDR_SIZE_OFS, {ram_code, rom_code});
		send_word('h14A, 16'($urandom));    // neighbour word that must not matter
		if (mount) begin
			@(posedge clk_sys);
			#0.5;
			img_mounted  = 1'b1;
			img_readonly = readonly;
			@(posedge clk_sys);
			#0.5 img_mounted = 1'b0;
		end
		@(posedge clk_sys);
		#0.5;
		dl_active    = 1'b0;
		img_readonly = 1'b0;
		m_ram_code   = ram_code;
		if (mbc_type >= 8'd1 && mbc_type <= 8'd3)
			m_kind = MBC_1;
		else if (mbc_type >= 8'd25 && mbc_type <= 8'd30)
			m_kind = MBC_5;
		else
			m_kind = MBC_NONE;
		m_rom_mask = (rom_code <= 8'd8) ? rom_bank_t'((1 << (rom_code + 1)) - 1) : 9'd127;
		m_ram_mask = (ram_code <= 8'd2) ? 4'd0 : ((ram_code == 8'd3) ? 4'd3 : 4'd15);
	endtask

	task automatic cpu_write(input logic [15:0] a, input cart_byte_t d);
		@(posedge clk_sys);
		#0.5;
		cart_addr = a;
		cart_di   = d;
		cart_wr   = 1'b1;
		case (a[15:13])
			3'd0: m_ram_en = (d[3:0] == `RAM_KEY);
			3'd1: begin
				if (m_kind == MBC_5 && a[12])
					m_rom_bank[8] = d[0];
				else if (m_kind == MBC_5)
					m_rom_bank[7:0] = d;
				else
					m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};    // 0 reads as 1
			end
			3'd2: m_ram_bank = (m_kind == MBC_5) ? d[3:0] : {2'b00, d[1:0]};
			3'd3: begin
				if (m_kind == MBC_1)
					m_mode = d[0];
			end
			3'd5: begin
				if (m_ram_en)
					model_ram[cram_ref(a)] = d;
			end
			default: ;
		endcase
		@(posedge clk_sys);
		#0.5 cart_wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] a);
		@(posedge clk_sys);
		#0.5;
		cart_addr = a;
		cart_rd   = 1'b1;
		exp_q.push_back(m_ram_en ? model_ram[cram_ref(a)] : 8'hFF);    // closed ram reads FF
		@(posedge clk_sys);
		#0.5 cart_rd = 1'b0;
	endtask

	task automatic check_rom(input logic [15:0] a);
		logic [`ROM_ADDR_W-1:0] exp;
		@(posedge clk_sys);
		#0.5 cart_addr = a;
		@(negedge clk_sys);    // combinational path settled
		exp = rom_ref(a);
		checks++;
		assert (rom_addr === exp) else begin
			errors++;
			$display("Error %s: rom_addr for %h expected %h actual %h",
				test_name, a, exp, rom_addr);
		end
	endtask

	task automatic kick(input logic load);
		@(posedge clk_sys);
		#0.5;
		bk_load = load;
		bk_save = !load;
		@(posedge clk_sys);
		#0.5;
		bk_load = 1'b0;
		bk_save = 1'b0;
	endtask

	// host side of the block port for one job from first request to bk_busy low
	task automatic serve_block(input logic load);
		int count;
		int i;
		int base;
		dl_word_t w;
		count = 0;
		@(negedge clk_sys);
		checks++;
		assert (bk_busy) else begin
			errors++;
			$display("%s: bk_busy did not rise after the trigger", test_name);
		end
		while (bk_busy) begin
			if (sd_rd || sd_wr) begin
				checks++;
				assert (sd_rd == load && sd_wr == !load && sd_lba == 32'(count)) else begin
					errors++;
					$display("Error %s: expected lba %0d rd %b wr %b actual lba %0d rd %b wr %b",
						test_name, count, load, !load, sd_lba, sd_rd, sd_wr);
				end
				repeat ($urandom_range(0, 3)) @(posedge clk_sys);    // host back-pressure
				@(posedge clk_sys);
				#0.5 sd_ack = 1'b1;
				base = (count % 256) * 512;
				for (i = 0; i <= 256; i++) begin
					@(posedge clk_sys);
					#0.5;
					if (i < 256)
						sd_buff_addr = 8'(i);
					if (load) begin
						w            = 16'($urandom);
						sd_buff_wr   = (i < 256);
						sd_buff_dout = w;
						if (i < 256) begin
							model_ram[base + 2*i]     = w[7:0];     // even byte low
							model_ram[base + 2*i + 1] = w[15:8];
						end
					end else begin
						@(negedge clk_sys);    // word i-1 out after one cycle
						if (i > 0) begin
							w = {model_ram[base + 2*i - 1], model_ram[base + 2*i - 2]};
							checks++;
							assert (sd_buff_din === w) else begin
								errors++;
								$display("Error %s: lba %0d word %0d expected %h actual %h",
									test_name, count, i - 1, w, sd_buff_din);
							end
						end
					end
				end
				@(posedge clk_sys);
				#0.5 sd_ack = 1'b0;
				count++;
				@(posedge clk_sys);
			end
			@(negedge clk_sys);
		end
		checks++;
		assert (count == last_lba_ref(m_ram_code) + 1 && !sd_rd && !sd_wr) else begin
			errors++;
			$display("Error %s: sector count expected %0d actual %0d",
				test_name, last_lba_ref(m_ram_code) + 1, count);
		end
	endtask

	task automatic expect_refusal(input logic load);
		int i;
		logic seen;
		seen = 1'b0;
		kick(load);
		for (i = 0; i < 50; i++) begin
			@(negedge clk_sys);
			seen = seen | sd_rd | sd_wr | bk_busy;
		end
		checks++;
		assert (!seen) else begin
			errors++;
			$display("%s: a block request came up although backup is not allowed", test_name);
		end
	endtask

	// --------------------
	// cart_do compare
	// --------------------
	always @(posedge clk_sys) rd_seen <= cart_rd;

	always @(negedge clk_sys) begin
		if (rd_seen) begin
			rd_exp = exp_q.pop_front();
			checks++;
			assert (cart_do === rd_exp) else begin
				errors++;
				$display("Error %s: cart_do expected %h actual %h", test_name, rd_exp, cart_do);
			end
		end
	end

	// --------------------
	// test sequence
	// --------------------
	initial begin
		int k;
		cart_byte_t d;
		logic [8:0] v;
		ram_bank_t b;
		logic [15:0] a;
		ram_bank_t bank_q[$];
		logic [15:0] addr_q[$];
		void'($urandom(32'h8df0_b5da));
		reset        = 1'b1;
		{dl_active, dl_wr, cart_rd, cart_wr, img_mounted, img_readonly} = '0;
		{bk_load, bk_save, sd_ack, sd_buff_wr} = '0;
		dl_addr      = '0;
		dl_data      = '0;
		cart_addr    = '0;
		cart_di      = '0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		m_kind       = MBC_NONE;    // header reads zero after reset
		m_rom_bank   = 9'd1;
		m_rom_mask   = 9'd1;
		m_ram_bank   = 4'd0;
		m_ram_mask   = 4'd0;
		m_ram_code   = 8'd0;
		m_mode       = 1'b0;
		m_ram_en     = 1'b0;
		repeat (5) @(posedge clk_sys);
		#0.5 reset = 1'b0;

		test_name = "mbc1_rom";    // small mask mirrors and large mask shows mode bits
		for (k = 0; k < 2; k++) begin
			download(8'd3, k ? 8'd6 : 8'd2, 8'd2, 1'b0, 1'b0);
			repeat (40) begin
				d = ($urandom_range(0, 3) == 0) ? 8'h00 : 8'($urandom);
				cpu_write(16'h2000 | 16'($urandom_range(0, 16'h1FFF)), d);
				cpu_write(16'h4000 | 16'($urandom_range(0, 16'h1FFF)), 8'($urandom));
				cpu_write(16'h6000 | 16'($urandom_range(0, 16'h1FFF)), 8'($urandom));
				check_rom(16'($urandom_range(0, 16'h3FFF)));
				check_rom(16'h4000 | 16'($urandom_range(0, 16'h3FFF)));
			end
		end

		test_name = "mbc5_rom";
		download(8'd27, 8'd8, 8'd3, 1'b0, 1'b0);
		repeat (60) begin
			v = ($urandom_range(0, 4) == 0) ? 9'd0 : 9'($urandom);
			cpu_write(16'h2000 | 16'($urandom_range(0, 16'h0FFF)), v[7:0]);
			cpu_write(16'h3000 | 16'($urandom_range(0, 16'h0FFF)), {7'($urandom), v[8]});
			check_rom(16'($urandom_range(0, 16'h3FFF)));
			check_rom(16'h4000 | 16'($urandom_range(0, 16'h3FFF)));
		end

		test_name = "cart_ram";
		cpu_write(16'h0000, 8'h00);
		repeat (8) cpu_read(16'hA000 | 16'($urandom_range(0, 16'h1FFF)));
		cpu_write(16'h1000 | 16'($urandom_range(0, 16'h0FFF)), {4'($urandom), `RAM_KEY});
		repeat (80) begin
			b = 4'($urandom);
			a = 16'hA000 | 16'($urandom_range(0, 16'h1FFF));
			cpu_write(16'h4000, {4'h0, b});
			cpu_write(a, 8'($urandom));
			bank_q.push_back(b);
			addr_q.push_back(a);
		end
		foreach (addr_q[j]) begin
			// bank bit 2 is masked off for ram code 3 so odd entries read through the alias
			cpu_write(16'h4000, {4'h0, bank_q[j] ^ (j[0] ? 4'h4 : 4'h0)});
			cpu_read(addr_q[j]);
		end
		cpu_write(16'h0000, 8'h0B);
		cpu_read(addr_q[0]);

		test_name = "load";
		download(8'd27, 8'd8, 8'd3, 1'b1, 1'b0);
		kick(1'b1);
		serve_block(1'b1);
		cpu_write(16'h0000, {4'h0, `RAM_KEY});
		repeat (60) begin
			cpu_write(16'h4000, 8'($urandom_range(0, 15)));
			cpu_read(16'hA000 | 16'($urandom_range(0, 16'h1FFF)));
		end

		test_name = "save";
		repeat (20) begin
			cpu_write(16'h4000, 8'($urandom_range(0, 15)));
			cpu_write(16'hA000 | 16'($urandom_range(0, 16'h1FFF)), 8'($urandom));
		end
		kick(1'b0);
		serve_block(1'b0);

		test_name = "refuse_readonly";
		download(8'd27, 8'd8, 8'd3, 1'b1, 1'b1);
		expect_refusal(1'b0);
		expect_refusal(1'b1);
		test_name = "refuse_no_battery";
		download(8'd25, 8'd8, 8'd3, 1'b1, 1'b0);
		expect_refusal(1'b0);
		expect_refusal(1'b1);

		repeat (2) @(negedge clk_sys);    // let the last read compare
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// --------------------
	// watchdog
	// --------------------
	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk_sys);
		$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYC);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/cart_pkg.sv
rtl/cart_header.sv
rtl/mbc_regs.sv
rtl/cart_ram.sv
rtl/backup_sequencer.sv
rtl/cart_top.sv
testbench/tb_cart.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_cart -f all.f -Mdir obj_dir -o tb_cart

./obj_dir/tb_cart | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
exit 1
